/* rtl/cpuPkg.sv */
// cpu core shared types
package cpuPkg;

    localparam int wordW = 16;
    localparam int numRegs = 8;

    typedef logic [wordW-1:0] word_t;
    typedef logic [$clog2(numRegs)-1:0] regNum_t;
    typedef logic [2:0] opcode_t;
    typedef logic [1:0] aluOp_t;
    typedef logic [1:0] shift_t;
    typedef logic [1:0] regSel_t;

    // instruction layout, low bit of each field
    // opcode 15:13, op 12:11, Rn 10:8, Rd 7:5, shift 4:3, Rm 2:0, imm8 7:0
    localparam int opcodeLsb = 13;
    localparam int opLsb = 11;
    localparam int rnLsb = 8;
    localparam int rdLsb = 5;
    localparam int shiftLsb = 3;
    localparam int rmLsb = 0;
    localparam int imm8W = 8;

    // top field
    localparam opcode_t opMove = 3'b110;
    localparam opcode_t opAlu = 3'b101;

    // op field under opMove
    localparam aluOp_t opMovImm = 2'b10;
    localparam aluOp_t opMovReg = 2'b00;

    // alu operations
    localparam aluOp_t aluAdd = 2'b00;
    localparam aluOp_t aluCmp = 2'b01;
    localparam aluOp_t aluAnd = 2'b10;
    localparam aluOp_t aluMvn = 2'b11;

    // shift applied to the B operand
    localparam shift_t shNone = 2'b00;
    localparam shift_t shLeft = 2'b01;
    localparam shift_t shRightLogical = 2'b10;
    localparam shift_t shRightArith = 2'b11;

    // register field picked by the controller
    localparam regSel_t selRn = 2'b00;
    localparam regSel_t selRd = 2'b01;
    localparam regSel_t selRm = 2'b10;

endpackage

/* rtl/instructionDecoder.sv */
// instruction register and decoder
`timescale 1ns/1ps

module instructionDecoder (
    input  logic            clk,
    input  logic            reset,
    input  logic            load,
    input  cpuPkg::word_t   instr,
    input  cpuPkg::regSel_t nsel,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::aluOp_t  op,
    output cpuPkg::regNum_t readNum,
    output cpuPkg::regNum_t writeNum,
    output cpuPkg::word_t   sximm8,
    output cpuPkg::shift_t  shift,
    output cpuPkg::aluOp_t  aluOp
);
    import cpuPkg::*;

    word_t   instrReg;
    regNum_t selectedReg;
    logic    isMovImm;

    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;
        end else if (load) begin
            instrReg <= instr;
        end
    end

    assign opcode = instrReg[opcodeLsb +: $bits(opcode_t)];
    assign op = instrReg[opLsb +: $bits(aluOp_t)];
    assign isMovImm = (opcode == opMove) && (op == opMovImm);

    // imm8 shares bits with Rd, shift and Rm
    assign sximm8 = {{(wordW - imm8W){instrReg[imm8W-1]}}, instrReg[imm8W-1:0]};
    assign shift = isMovImm ? shNone : instrReg[shiftLsb +: $bits(shift_t)];

    // register form of MOV runs through the adder with A forced to zero
    assign aluOp = (opcode == opMove) ? aluAdd : op;

    always_comb begin
        case (nsel)
            selRn:   selectedReg = instrReg[rnLsb +: $bits(regNum_t)];
            selRd:   selectedReg = instrReg[rdLsb +: $bits(regNum_t)];
            default: selectedReg = instrReg[rmLsb +: $bits(regNum_t)];
        endcase
    end

    assign readNum = selectedReg;
    assign writeNum = selectedReg;

endmodule

/* rtl/registerFile.sv */
// eight entry register file
`timescale 1ns/1ps

module registerFile (
    input  logic            clk,
    input  logic            write,
    input  cpuPkg::regNum_t writeNum,
    input  cpuPkg::regNum_t readNum,
    input  cpuPkg::word_t   dataIn,
    output cpuPkg::word_t   dataOut
);
    import cpuPkg::*;

    word_t regs [numRegs];

    // single write port, lands on the clock edge
    always_ff @(posedge clk) begin
        if (write) begin
            regs[writeNum] <= dataIn;
        end
    end

    // read is combinational so A or B can load in the same cycle
    assign dataOut = regs[readNum];

    // decoder must present a clean register number whenever the controller writes
    writeNumKnown: assert property (
        @(posedge clk) write |-> !$isunknown(writeNum)
    ) else $error("register file write with unknown writeNum");

endmodule

/* rtl/shifterAlu.sv */
// B operand shifter and ALU
`timescale 1ns/1ps

module shifterAlu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::shift_t shift,
    input  cpuPkg::aluOp_t aluOp,
    output cpuPkg::word_t  result,
    output logic           zero,
    output logic           negative,
    output logic           overflow
);
    import cpuPkg::*;

    word_t shifted;
    word_t sum;
    word_t diff;
    logic  signA;
    logic  signB;

    always_comb begin
        case (shift)
            shLeft:         shifted = {b[wordW-2:0], 1'b0};
            shRightLogical: shifted = {1'b0, b[wordW-1:1]};
            // keep the sign bit
            shRightArith:   shifted = {b[wordW-1], b[wordW-1:1]};
            default:        shifted = b;
        endcase
    end

    assign sum = a + shifted;
    assign diff = a - shifted;
    assign signA = a[wordW-1];
    assign signB = shifted[wordW-1];

    always_comb begin
        overflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                result = sum;
                // same signs in, different sign out
                overflow = (signA == signB) && (sum[wordW-1] != signA);
            end
            aluCmp: begin
                result = diff;
                overflow = (signA != signB) && (diff[wordW-1] != signA);
            end
            aluAnd: result = a & shifted;
            default: result = ~shifted;
        endcase
    end

    assign zero = (result == '0);
    assign negative = result[wordW-1];

endmodule

/* rtl/datapath.sv */
// core datapath
`timescale 1ns/1ps

module datapath (
    input  logic            clk,
    input  logic            reset,
    input  logic            write,
    input  logic            loada,
    input  logic            loadb,
    input  logic            loadc,
    input  logic            loads,
    input  logic            asel,
    input  logic            writeSel,
    input  cpuPkg::regNum_t readNum,
    input  cpuPkg::regNum_t writeNum,
    input  cpuPkg::word_t   sximm8,
    input  cpuPkg::shift_t  shift,
    input  cpuPkg::aluOp_t  aluOp,
    output cpuPkg::word_t   out,
    output logic            statusZ,
    output logic            statusN,
    output logic            statusV
);
    import cpuPkg::*;

    word_t regData;
    word_t writeData;
    word_t aReg;
    word_t bReg;
    word_t cReg;
    word_t aluA;
    word_t aluResult;
    logic  aluZero;
    logic  aluNegative;
    logic  aluOverflow;

    // write back either the immediate or the C register
    assign writeData = writeSel ? sximm8 : cReg;

    registerFile registerFile_i (
        .clk      (clk),
        .write    (write),
        .writeNum (writeNum),
        .readNum  (readNum),
        .dataIn   (writeData),
        .dataOut  (regData)
    );

    always_ff @(posedge clk) begin
        if (loada) begin
            aReg <= regData;
        end
        if (loadb) begin
            bReg <= regData;
        end
    end

    // MOV register form and MVN ignore Rn
    assign aluA = asel ? '0 : aReg;

    shifterAlu shifterAlu_i (
        .a        (aluA),
        .b        (bReg),
        .shift    (shift),
        .aluOp    (aluOp),
        .result   (aluResult),
        .zero     (aluZero),
        .negative (aluNegative),
        .overflow (aluOverflow)
    );

    always_ff @(posedge clk) begin
        if (loadc) begin
            cReg <= aluResult;
        end
    end

    // status only changes on CMP
    always_ff @(posedge clk) begin
        if (reset) begin
            statusZ <= 1'b0;
            statusN <= 1'b0;
            statusV <= 1'b0;
        end else if (loads) begin
            statusZ <= aluZero;
            statusN <= aluNegative;
            statusV <= aluOverflow;
        end
    end

    assign out = cReg;

    // CMP must leave C untouched, so a result never goes to both places
    cOrStatus: assert property (
        @(posedge clk) disable iff (reset) !(loadc && loads)
    ) else $error("loadc and loads high together");

endmodule

/* rtl/controller.sv */
// multi-cycle instruction sequencer
`timescale 1ns/1ps

module controller (
    input  logic            clk,
    input  logic            reset,
    input  logic            s,
    input  cpuPkg::opcode_t opcode,
    input  cpuPkg::aluOp_t  op,
    output logic            w,
    output logic            write,
    output logic            loada,
    output logic            loadb,
    output logic            loadc,
    output logic            loads,
    output logic            asel,
    output logic            writeSel,
    output cpuPkg::regSel_t nsel
);
    import cpuPkg::*;

    typedef enum logic [3:0] {
        waiting,
        writeImm,
        loadA,
        loadA2,
        readRm,
        compute,
        writeRd,
        writeRd2,
        done
    } ctrlState_t;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       isCmp;
    logic       needsSettle;
    logic       zeroA;
    logic       validInstr;

    assign isCmp = (opcode == opAlu) && (op == aluCmp);
    // ADD and AND take the extra cycle after write back
    assign needsSettle = (opcode == opAlu) && ((op == aluAdd) || (op == aluAnd));
    assign zeroA = (opcode == opMove) || (op == aluMvn);
    assign validInstr = (opcode == opAlu)
                     || ((opcode == opMove) && ((op == opMovImm) || (op == opMovReg)));

    always_comb begin
        nextState = state;
        case (state)
            waiting: begin
                if (s && opcode == opMove) begin
                    if (op == opMovImm) begin
                        nextState = writeImm;
                    end else if (op == opMovReg) begin
                        nextState = readRm;
                    end
                end else if (s && opcode == opAlu) begin
                    nextState = (op == aluMvn) ? readRm : loadA;
                end
            end
            writeImm: nextState = done;
            loadA:    nextState = loadA2;
            loadA2:   nextState = readRm;
            readRm:   nextState = compute;
            compute:  nextState = isCmp ? done : writeRd;
            writeRd:  nextState = needsSettle ? writeRd2 : done;
            default:  nextState = waiting;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= waiting;
        end else begin
            state <= nextState;
        end
    end

    // w goes low on the accepting edge and back high as the instruction ends
    always_ff @(posedge clk) begin
        if (reset) begin
            w <= 1'b1;
        end else begin
            w <= (nextState == waiting);
        end
    end

    // strobes registered from the next state so they line up with it
    always_ff @(posedge clk) begin
        if (reset) begin
            write <= 1'b0;
            loada <= 1'b0;
            loadb <= 1'b0;
            loadc <= 1'b0;
            loads <= 1'b0;
        end else begin
            write <= (nextState == writeImm) || (nextState == writeRd);
            loada <= (nextState == loadA);
            loadb <= (nextState == readRm);
            loadc <= (nextState == compute) && !isCmp;
            loads <= (nextState == compute) && isCmp;
        end
    end

    always_ff @(posedge clk) begin
        case (nextState)
            readRm:  nsel <= selRm;
            writeRd: nsel <= selRd;
            default: nsel <= selRn;
        endcase
        asel <= zeroA;
        writeSel <= (nextState == writeImm);
    end

    noWriteWhenIdle: assert property (
        @(posedge clk) disable iff (reset) (state == waiting) |-> !write
    ) else $error("write high while waiting");

    startAccepted: assert property (
        @(posedge clk) disable iff (reset) (state == waiting && s && validInstr) |=> !w
    ) else $error("w still high after a valid start");

endmodule

/* rtl/cpuCore.sv */
// cpu core top level
`timescale 1ns/1ps

module cpuCore (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::word_t instr,
    input  logic          load,
    input  logic          s,
    output logic          w,
    output cpuPkg::word_t out,
    output logic          statusZ,
    output logic          statusN,
    output logic          statusV
);
    import cpuPkg::*;

    opcode_t opcode;
    aluOp_t  op;
    aluOp_t  aluOp;
    regNum_t readNum;
    regNum_t writeNum;
    word_t   sximm8;
    shift_t  shift;
    regSel_t nsel;
    logic    write;
    logic    loada;
    logic    loadb;
    logic    loadc;
    logic    loads;
    logic    asel;
    logic    writeSel;

    instructionDecoder instructionDecoder_i (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .instr    (instr),
        .nsel     (nsel),
        .opcode   (opcode),
        .op       (op),
        .readNum  (readNum),
        .writeNum (writeNum),
        .sximm8   (sximm8),
        .shift    (shift),
        .aluOp    (aluOp)
    );

    controller controller_i (
        .clk      (clk),
        .reset    (reset),
        .s        (s),
        .opcode   (opcode),
        .op       (op),
        .w        (w),
        .write    (write),
        .loada    (loada),
        .loadb    (loadb),
        .loadc    (loadc),
        .loads    (loads),
        .asel     (asel),
        .writeSel (writeSel),
        .nsel     (nsel)
    );

    datapath datapath_i (
        .clk      (clk),
        .reset    (reset),
        .write    (write),
        .loada    (loada),
        .loadb    (loadb),
        .loadc    (loadc),
        .loads    (loads),
        .asel     (asel),
        .writeSel (writeSel),
        .readNum  (readNum),
        .writeNum (writeNum),
        .sximm8   (sximm8),
        .shift    (shift),
        .aluOp    (aluOp),
        .out      (out),
        .statusZ  (statusZ),
        .statusN  (statusN),
        .statusV  (statusV)
    );

endmodule

/* tests/cpuCoreTb.sv */
// cpu core testbench
`timescale 1ns/1ps

module cpuCoreTb;
    import cpuPkg::*;

    localparam int idleTimeout = 40;
    localparam int randomCount = 30;
    // how an entry is run
    localparam logic [1:0] runPlain = 2'd0;
    localparam logic [1:0] runDoubleStart = 2'd1;
    localparam logic [1:0] runResetMid = 2'd2;

    typedef struct packed {
        word_t      instr;
        logic [1:0] mode;
        logic       chkOut;
        logic       chkStat;
        logic       computed;
        word_t      expOut;
        logic [2:0] expFlags;
    } entry_t;

    logic  clk;
    logic  reset;
    word_t instr;
    logic  load;
    logic  s;
    logic  w;
    word_t out;
    logic  statusZ;
    logic  statusN;
    logic  statusV;

    entry_t tbl[$];
    int     errors;
    // reference model state
    word_t  mRegs [numRegs];
    word_t  mC;
    logic   mZ;
    logic   mN;
    logic   mV;

    cpuCore cpuCore_i (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .load    (load),
        .s       (s),
        .w       (w),
        .out     (out),
        .statusZ (statusZ),
        .statusN (statusN),
        .statusV (statusV)
    );

    always #2 clk = ~clk;

    function automatic word_t movImm(regNum_t rn, logic [7:0] imm);
        return {opMove, opMovImm, rn, imm};
    endfunction

    function automatic word_t movReg(regNum_t rd, shift_t sh, regNum_t rm);
        return {opMove, opMovReg, 3'd0, rd, sh, rm};
    endfunction

    function automatic word_t aluInstr(aluOp_t op, regNum_t rn, regNum_t rd, shift_t sh,
                                       regNum_t rm);
        return {opAlu, op, rn, rd, sh, rm};
    endfunction

    function automatic word_t shiftOperand(word_t v, shift_t sh);
        case (sh)
            shLeft:         return v << 1;
            shRightLogical: return v >> 1;
            shRightArith:   return {v[15], v[15:1]};
            default:        return v;
        endcase
    endfunction

    // instruction semantics straight from the ISA description
    task automatic modelStep(input word_t ins);
        word_t a;
        word_t b;
        word_t d;
        a = mRegs[ins[10:8]];
        b = shiftOperand(mRegs[ins[2:0]], ins[4:3]);
        if (ins[15:13] == opMove && ins[12:11] == opMovImm) begin
            mRegs[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
        end else if (ins[15:13] == opMove) begin
            mC = b;
            mRegs[ins[7:5]] = mC;
        end else if (ins[12:11] == aluCmp) begin
            d = a - b;
            mZ = (d == '0);
            mN = d[15];
            mV = (a[15] != b[15]) && (d[15] != a[15]);
        end else begin
            case (ins[12:11])
                aluAdd:  mC = a + b;
                aluAnd:  mC = a & b;
                default: mC = ~b;
            endcase
            mRegs[ins[7:5]] = mC;
        end
    endtask

    // chk is {out, status}, flags is {Z, N, V}
    task automatic addEntry(input word_t ins, input logic [1:0] mode, input logic [1:0] chk,
                            input word_t expOut, input logic [2:0] flags);
        entry_t e;
        e.instr = ins;
        e.mode = mode;
        e.chkOut = chk[1];
        e.chkStat = chk[0];
        e.computed = 1'b0;
        e.expOut = expOut;
        e.expFlags = flags;
        tbl.push_back(e);
    endtask

    task automatic buildTable();
        entry_t e;
        int     kind;
        // sign extension, then plain register moves
        addEntry(movImm(3'd0, 8'hFD), runPlain, 2'b00, 16'h0000, 3'b000);
        addEntry(movImm(3'd1, 8'h05), runPlain, 2'b00, 16'h0000, 3'b000);
        addEntry(movReg(3'd2, shNone, 3'd0), runPlain, 2'b10, 16'hFFFD, 3'b000);
        addEntry(movReg(3'd3, shNone, 3'd1), runPlain, 2'b10, 16'h0005, 3'b000);
        // each shift code
        addEntry(movReg(3'd4, shLeft, 3'd0), runPlain, 2'b10, 16'hFFFA, 3'b000);
        addEntry(movReg(3'd4, shRightLogical, 3'd0), runPlain, 2'b10, 16'h7FFE, 3'b000);
        addEntry(movReg(3'd4, shRightArith, 3'd0), runPlain, 2'b10, 16'hFFFE, 3'b000);
        addEntry(movImm(3'd5, 8'hFF), runPlain, 2'b00, 16'h0000, 3'b000);
        addEntry(movReg(3'd6, shRightLogical, 3'd5), runPlain, 2'b10, 16'h7FFF, 3'b000);
        // alu ops each followed by a read back of Rd
        addEntry(aluInstr(aluAdd, 3'd1, 3'd7, shLeft, 3'd1), runPlain, 2'b10, 16'h000F, 3'b000);
        addEntry(movReg(3'd4, shNone, 3'd7), runPlain, 2'b10, 16'h000F, 3'b000);
        addEntry(aluInstr(aluAnd, 3'd0, 3'd7, shRightArith, 3'd6), runPlain, 2'b10, 16'h3FFD,
                 3'b000);
        addEntry(movReg(3'd4, shNone, 3'd7), runPlain, 2'b10, 16'h3FFD, 3'b000);
        addEntry(aluInstr(aluMvn, 3'd0, 3'd7, shLeft, 3'd1), runPlain, 2'b10, 16'hFFF5, 3'b000);
        addEntry(movReg(3'd4, shNone, 3'd7), runPlain, 2'b10, 16'hFFF5, 3'b000);
        // compares leave C alone
        addEntry(aluInstr(aluCmp, 3'd2, 3'd0, shNone, 3'd0), runPlain, 2'b11, 16'hFFF5, 3'b100);
        addEntry(aluInstr(aluCmp, 3'd1, 3'd0, shNone, 3'd6), runPlain, 2'b11, 16'hFFF5, 3'b010);
        addEntry(aluInstr(aluCmp, 3'd6, 3'd0, shNone, 3'd5), runPlain, 2'b11, 16'hFFF5, 3'b011);
        // a second run would give 0x0014
        addEntry(aluInstr(aluAdd, 3'd3, 3'd3, shNone, 3'd3), runDoubleStart, 2'b10, 16'h000A,
                 3'b000);
        addEntry(movReg(3'd4, shNone, 3'd3), runPlain, 2'b10, 16'h000A, 3'b000);
        addEntry(aluInstr(aluAdd, 3'd1, 3'd7, shLeft, 3'd1), runResetMid, 2'b00, 16'h0000,
                 3'b000);
        addEntry(movImm(3'd7, 8'h12), runPlain, 2'b01, 16'h0000, 3'b000);
        addEntry(movReg(3'd4, shNone, 3'd3), runPlain, 2'b10, 16'h000A, 3'b000);
        for (int k = 0; k < randomCount; k++) begin
            kind = int'($urandom % 5);
            if (kind == 0) begin
                e.instr = movImm(3'($urandom), 8'($urandom));
            end else begin
                e.instr = aluInstr(aluOp_t'(kind - 1), 3'($urandom), 3'($urandom),
                                   shift_t'($urandom), 3'($urandom));
            end
            e.mode = runPlain;
            e.chkOut = 1'b1;
            e.chkStat = 1'b1;
            e.computed = 1'b1;
            tbl.push_back(e);
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("error %s got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error %s got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    // latch, start, then wait for w to come back high
    task automatic applyEntry(input word_t ins, input logic [1:0] mode, output logic timedOut);
        int    cycles;
        word_t prevOut;
        timedOut = 1'b0;
        @(posedge clk);
        instr <= ins;
        load <= 1'b1;
        @(posedge clk);
        load <= 1'b0;
        s <= 1'b1;
        @(posedge clk);
        s <= 1'b0;
        @(negedge clk);
        if (w !== 1'b0) begin
            $display("w did not fall after start of instruction 0x%h", ins);
            errors++;
        end
        prevOut = out;
        if (mode == runDoubleStart) begin
            // pulse s again once C holds the result and w is still low
            cycles = 0;
            while (out === prevOut && w !== 1'b1 && cycles < idleTimeout) begin
                @(negedge clk);
                cycles++;
            end
            if (w !== 1'b1) begin
                @(posedge clk);
                s <= 1'b1;
                @(posedge clk);
                s <= 1'b0;
            end
        end else if (mode == runResetMid) begin
            @(posedge clk);
            reset <= 1'b1;
            @(posedge clk);
            reset <= 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (w !== 1'b1 && cycles < idleTimeout);
        if (w !== 1'b1) begin
            $display("timeout, w never returned high for instruction 0x%h", ins);
            timedOut = 1'b1;
            errors++;
        end
    endtask

    initial begin
        entry_t e;
        logic   timedOut;
        int     errBefore;
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        load = 1'b0;
        s = 1'b0;
        errors = 0;
        void'($urandom(9));
        buildTable();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkFlag("w", w, 1'b1);
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            // reset clears status but not the register file or C
            if (e.mode == runResetMid) begin
                {mZ, mN, mV} = 3'b000;
            end else begin
                modelStep(e.instr);
            end
            if (e.computed) begin
                e.expOut = mC;
                e.expFlags = {mZ, mN, mV};
            end
            errBefore = errors;
            applyEntry(e.instr, e.mode, timedOut);
            if (!timedOut && e.chkOut) begin
                checkWord("out", out, e.expOut);
            end
            if (!timedOut && e.chkStat) begin
                checkFlag("statusZ", statusZ, e.expFlags[2]);
                checkFlag("statusN", statusN, e.expFlags[1]);
                checkFlag("statusV", statusV, e.expFlags[0]);
            end
            $display("test %0d instr 0x%h %s", i, e.instr, (errors == errBefore) ? "ok" : "bad");
        end
        $display("%0d tests run, %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/cpuPkg.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/shifterAlu.sv
rtl/datapath.sv
rtl/controller.sv
rtl/cpuCore.sv
tests/cpuCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu core simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module cpuCoreTb -o cpuCoreSim; then
    echo "verilator build returned an error"
    exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi

exit 0
